/* source/cachePkg.sv */
`default_nettype none

package cachePkg;

    // 64-byte lines of 32-bit words
    localparam int LINE_BEATS = 16;
    localparam int TAG_BITS = 26;

    typedef struct packed {
        logic        valid;
        logic        exception;
        logic [5:0]  sqN;
        logic [31:0] addr;
    } AguUop;

    typedef struct packed {
        logic       taken;
        logic [5:0] sqN;
    } BranchProv;

    // we = 1 is writeback, we = 0 is fill
    typedef struct packed {
        logic        ce;
        logic        we;
        logic [9:0]  sramAddr;
        logic [31:0] extAddr;
    } LineReq;

    typedef enum logic [2:0] {
        Idle,
        Evict,
        WaitEvict,
        Fill,
        WaitFill
    } CtrlState;

    // Younger than a taken branch means flushed
    // Sequence numbers wrap, so compare the signed difference
    function automatic logic isFlushed(BranchProv br, logic [5:0] sqN);
        logic signed [5:0] diff;
        diff = sqN - br.sqN;
        return br.taken && (diff > 0);
    endfunction

endpackage

`default_nettype wire

/* source/uopIngress.sv */
`default_nettype none

module uopIngress
    import cachePkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  AguUop     uopIn,
    input  BranchProv branch,
    input  logic      stall,
    output AguUop     stageUop
);

    AguUop stageReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            stageReg.valid <= 1'b0;
        end else if (!stall) begin
            stageReg <= uopIn;
            if (isFlushed(branch, uopIn.sqN)) begin
                stageReg.valid <= 1'b0;
            end
        end else begin
            // Held micro-op can still be flushed
            if (isFlushed(branch, stageReg.sqN)) begin
                stageReg.valid <= 1'b0;
            end
        end
    end

    assign stageUop = stageReg;

    // Held entry only changes by losing its valid bit
    stageHoldsUnderStall: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> (stageUop == $past(stageUop)) || !stageUop.valid
    );

endmodule

`default_nettype wire

/* source/cacheController.sv */
`default_nettype none

module cacheController
    import cachePkg::*;
#(
    parameter int SIZE = 64
)
(
    input  logic      clk,
    input  logic      rst,
    input  AguUop     stageUop,
    input  BranchProv branch,
    input  logic      busy,
    output logic      stall,
    output AguUop     uopOut,
    output LineReq    lineReq
);

    localparam int IDX_W = $clog2(SIZE);
    localparam int BEAT_W = $clog2(LINE_BEATS);

    typedef struct packed {
        logic                valid;
        logic                used;
        logic [TAG_BITS-1:0] tag;
    } TagEntry;

    TagEntry tagTable [SIZE];

    CtrlState         state;
    AguUop            missUop;
    logic [IDX_W-1:0] sweepPtr;
    logic [IDX_W-1:0] victimIdx;

    logic             hit;
    logic [IDX_W-1:0] hitIdx;
    logic             reqDone;

    // Word index of the first beat of an entry in the data array
    function automatic logic [9:0] sramBase(logic [IDX_W-1:0] idx);
        return 10'({idx, {BEAT_W{1'b0}}});
    endfunction

    // Fully associative lookup
    always_comb begin
        hit = 1'b0;
        hitIdx = '0;
        for (int i = 0; i < SIZE; i++) begin
            if (tagTable[i].valid && tagTable[i].tag == stageUop.addr[31 -: TAG_BITS]) begin
                hit = 1'b1;
                hitIdx = IDX_W'(i);
            end
        end
    end

    // ce is still visible in the cycle before busy rises
    assign reqDone = !lineReq.ce && !busy;

    assign stall = (state != Idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            sweepPtr <= '0;
            missUop.valid <= 1'b0;
            uopOut.valid <= 1'b0;
            lineReq.ce <= 1'b0;
            for (int i = 0; i < SIZE; i++) begin
                tagTable[i].valid <= 1'b0;
                tagTable[i].used <= 1'b0;
            end
        end else begin
            uopOut.valid <= 1'b0;
            lineReq.ce <= 1'b0;

            if (isFlushed(branch, missUop.sqN)) begin
                missUop.valid <= 1'b0;
            end

            case (state)
                Idle: begin
                    if (stageUop.valid && !isFlushed(branch, stageUop.sqN)) begin
                        if (stageUop.exception || hit) begin
                            uopOut <= stageUop;
                            if (hit) begin
                                tagTable[hitIdx].used <= 1'b1;
                            end
                        end else begin
                            missUop <= stageUop;
                            state <= Evict;
                        end
                    end
                end

                // Clock sweep for a victim
                Evict: begin
                    if (!tagTable[sweepPtr].valid) begin
                        victimIdx <= sweepPtr;
                        state <= Fill;
                    end else if (tagTable[sweepPtr].used) begin
                        tagTable[sweepPtr].used <= 1'b0;
                        sweepPtr <= (sweepPtr == IDX_W'(SIZE - 1)) ? '0 : sweepPtr + 1'b1;
                    end else begin
                        // All resident lines are dirty
                        lineReq <= '{
                            ce: 1'b1,
                            we: 1'b1,
                            sramAddr: sramBase(sweepPtr),
                            extAddr: {tagTable[sweepPtr].tag, 6'b0}
                        };
                        tagTable[sweepPtr].valid <= 1'b0;
                        victimIdx <= sweepPtr;
                        state <= WaitEvict;
                    end
                end

                WaitEvict: begin
                    if (reqDone) begin
                        state <= Fill;
                    end
                end

                Fill: begin
                    lineReq <= '{
                        ce: 1'b1,
                        we: 1'b0,
                        sramAddr: sramBase(victimIdx),
                        extAddr: {missUop.addr[31 -: TAG_BITS], 6'b0}
                    };
                    tagTable[victimIdx].tag <= missUop.addr[31 -: TAG_BITS];
                    tagTable[victimIdx].used <= 1'b1;
                    state <= WaitFill;
                end

                WaitFill: begin
                    if (reqDone) begin
                        // Line becomes resident even if the waiter was flushed
                        tagTable[victimIdx].valid <= 1'b1;
                        if (missUop.valid && !isFlushed(branch, missUop.sqN)) begin
                            uopOut <= missUop;
                        end
                        missUop.valid <= 1'b0;
                        state <= Idle;
                    end
                end

                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    ceOnlyWhenIdle: assert property (
        @(posedge clk) disable iff (rst)
        lineReq.ce |-> !busy
    );

    noOutputDuringFill: assert property (
        @(posedge clk) disable iff (rst)
        (state == WaitFill) |-> !uopOut.valid
    );

endmodule

`default_nettype wire

/* source/memController.sv */
`default_nettype none

module memController
    import cachePkg::*;
#(
    parameter int BEAT_GAP = 0
)
(
    input  logic        clk,
    input  logic        rst,
    input  LineReq      lineReq,
    output logic        busy,
    output logic        memValid,
    output logic        memWrite,
    output logic [31:0] memAddr
);

    localparam int BEAT_W = $clog2(LINE_BEATS);
    localparam int GAP_W = (BEAT_GAP > 0) ? $clog2(BEAT_GAP + 1) : 1;

    logic [BEAT_W-1:0] beatCnt;
    logic [GAP_W-1:0]  gapCnt;
    logic              lastBeat;

    assign lastBeat = (beatCnt == BEAT_W'(LINE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            memValid <= 1'b0;
            beatCnt <= '0;
            gapCnt <= '0;
        end else if (!busy) begin
            if (lineReq.ce) begin
                // First beat goes out right after the strobe
                busy <= 1'b1;
                memValid <= 1'b1;
                memWrite <= lineReq.we;
                memAddr <= {lineReq.extAddr[31:2], 2'b00};
                beatCnt <= '0;
                gapCnt <= '0;
            end
        end else if (memValid) begin
            if (lastBeat) begin
                busy <= 1'b0;
                memValid <= 1'b0;
            end else begin
                beatCnt <= beatCnt + 1'b1;
                memAddr <= memAddr + 32'd4;
                if (BEAT_GAP > 0) begin
                    memValid <= 1'b0;
                    gapCnt <= GAP_W'(BEAT_GAP - 1);
                end
            end
        end else begin
            // Idle cycles between beats
            if (gapCnt == '0) begin
                memValid <= 1'b1;
            end else begin
                gapCnt <= gapCnt - 1'b1;
            end
        end
    end

    // Requests must be line aligned and never overlap a burst
    requestWellFormed: assert property (
        @(posedge clk) disable iff (rst)
        lineReq.ce |-> !busy
            && lineReq.sramAddr[BEAT_W-1:0] == '0
            && lineReq.extAddr[5:0] == '0
    );

endmodule

`default_nettype wire

/* source/cacheSubsystem.sv */
`default_nettype none

module cacheSubsystem
    import cachePkg::*;
#(
    parameter int SIZE = 4,
    parameter int BEAT_GAP = 0
)
(
    input  logic        clk,
    input  logic        rst,
    input  AguUop       uopIn,
    input  BranchProv   branch,
    output logic        stall,
    output AguUop       uopOut,
    output logic        memValid,
    output logic        memWrite,
    output logic [31:0] memAddr
);

    AguUop  stageUop;
    LineReq lineReq;
    logic   busy;

    uopIngress u_uopIngress (
        .clk      (clk),
        .rst      (rst),
        .uopIn    (uopIn),
        .branch   (branch),
        .stall    (stall),
        .stageUop (stageUop)
    );

    cacheController #(
        .SIZE (SIZE)
    ) u_cacheController (
        .clk      (clk),
        .rst      (rst),
        .stageUop (stageUop),
        .branch   (branch),
        .busy     (busy),
        .stall    (stall),
        .uopOut   (uopOut),
        .lineReq  (lineReq)
    );

    memController #(
        .BEAT_GAP (BEAT_GAP)
    ) u_memController (
        .clk      (clk),
        .rst      (rst),
        .lineReq  (lineReq),
        .busy     (busy),
        .memValid (memValid),
        .memWrite (memWrite),
        .memAddr  (memAddr)
    );

endmodule

`default_nettype wire

/* dv/cacheSubsystemTb.sv */
`default_nettype none

module cacheSubsystemTb
    import cachePkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam string STIM_FILE = "dv/cacheStimulus.txt";
    localparam int WORDS_PER_LINE = 16;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic        write;
        logic [31:0] base;
        logic [7:0]  beats;
    } Burst;

    logic        clk;
    logic        rst;
    AguUop       uopIn;
    BranchProv   branch;
    logic        stall;
    AguUop       uopOut;
    logic        memValid;
    logic        memWrite;
    logic [31:0] memAddr;

    Burst        bursts[$];
    Burst        openBurst;
    logic        burstOpen;
    logic [31:0] flushLine;

    cacheSubsystem #(
        .SIZE     (4),
        .BEAT_GAP (0)
    ) u_cacheSubsystem (
        .clk      (clk),
        .rst      (rst),
        .uopIn    (uopIn),
        .branch   (branch),
        .stall    (stall),
        .uopOut   (uopOut),
        .memValid (memValid),
        .memWrite (memWrite),
        .memAddr  (memAddr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportMismatch(string sig, logic [63:0] expected, logic [63:0] actual);
        $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, sig, expected, actual);
        abortRun();
    endtask

    task automatic reportProblem(string what);
        $display("t=%0t %s", $time, what);
        abortRun();
    endtask

    task automatic tick();
        @(negedge clk);
    endtask

    function automatic logic [31:0] lineBase(logic [31:0] addr);
        return addr & ~32'h3f;
    endfunction

    // One record per run of memValid
    // Beats climb by one word
    always @(negedge clk) begin : burstMonitor
        logic [31:0] nextAddr;
        if (rst) begin
            burstOpen = 1'b0;
        end else if (memValid) begin
            if (!burstOpen) begin
                openBurst = '{write: memWrite, base: memAddr, beats: 8'd1};
                burstOpen = 1'b1;
            end else begin
                nextAddr = openBurst.base + 32'(openBurst.beats) * 32'd4;
                assert (memAddr == nextAddr)
                    else reportMismatch("memAddr", 64'(nextAddr), 64'(memAddr));
                assert (memWrite == openBurst.write)
                    else reportMismatch("memWrite", 64'(openBurst.write), 64'(memWrite));
                openBurst.beats = openBurst.beats + 8'd1;
            end
        end else if (burstOpen) begin
            bursts.push_back(openBurst);
            burstOpen = 1'b0;
        end
    end

    task automatic checkQuiet();
        assert (!stall) else reportMismatch("stall", 64'd0, 64'(stall));
        assert (!uopOut.valid) else reportMismatch("uopOut.valid", 64'd0, 64'(uopOut.valid));
        assert (!memValid) else reportMismatch("memValid", 64'd0, 64'(memValid));
    endtask

    task automatic waitStallLow();
        int n;
        n = 0;
        while (stall) begin
            if (n == WAIT_LIMIT) begin
                reportProblem("stall stayed high and the next micro-op could not be sent");
            end else begin
                tick();
                n++;
            end
        end
    endtask

    task automatic checkBurst(Burst b, logic write, logic [31:0] base);
        assert (b.write == write) else reportMismatch("memWrite", 64'(write), 64'(b.write));
        assert (b.base == base) else reportMismatch("memAddr", 64'(base), 64'(b.base));
        assert (b.beats == 8'(WORDS_PER_LINE))
            else reportMismatch("burst beats", 64'(WORDS_PER_LINE), 64'(b.beats));
    endtask

    // Output register holds it right after the edge that follows acceptance
    task automatic checkHit(AguUop uop);
        tick();
        assert (uopOut == uop) else reportMismatch("uopOut", 64'(uop), 64'(uopOut));
        assert (bursts.size() == 0 && !memValid)
            else reportProblem("a memory burst occurred on the hit path");
    endtask

    task automatic checkMiss(AguUop uop, logic evict, logic [31:0] evictBase);
        int n;
        n = 0;
        tick();
        while (!uopOut.valid) begin
            assert (stall) else reportMismatch("stall", 64'd1, 64'(stall));
            if (n == WAIT_LIMIT) begin
                reportProblem("the missing micro-op never came out on uopOut");
            end else begin
                tick();
                n++;
            end
        end
        assert (uopOut == uop) else reportMismatch("uopOut", 64'(uop), 64'(uopOut));
        assert (!stall) else reportMismatch("stall", 64'd0, 64'(stall));
        assert (bursts.size() == (evict ? 2 : 1))
            else reportMismatch("burst count", 64'(evict ? 2 : 1), 64'(bursts.size()));
        if (evict) begin
            checkBurst(bursts.pop_front(), 1'b1, evictBase);
        end
        checkBurst(bursts.pop_front(), 1'b0, lineBase(uop.addr));
    endtask

    task automatic driveUop(logic [31:0] addr, int sqN, int exc, string outcome);
        AguUop uop;
        logic [31:0] evictBase;
        uop.valid = 1'b1;
        uop.exception = (exc != 0);
        uop.sqN = 6'(sqN);
        uop.addr = addr;
        waitStallLow();
        uopIn = uop;
        tick();
        uopIn = '0;
        assert (!uopOut.valid) else reportMismatch("uopOut.valid", 64'd0, 64'(uopOut.valid));
        if (outcome == "flush") begin
            // Branch command follows and drives in this same cycle
            flushLine = lineBase(addr);
        end else if (outcome == "hit") begin
            checkHit(uop);
        end else if (outcome == "miss") begin
            checkMiss(uop, 1'b0, '0);
        end else if ($sscanf(outcome, "%h", evictBase) == 1) begin
            checkMiss(uop, 1'b1, evictBase);
        end else begin
            reportProblem($sformatf("unknown expected outcome %s", outcome));
        end
    endtask

    task automatic driveBranch(int sqN);
        int n;
        Burst b;
        branch.taken = 1'b1;
        branch.sqN = 6'(sqN);
        tick();
        branch = '0;
        n = 0;
        assert (!uopOut.valid) else reportMismatch("uopOut.valid", 64'd0, 64'(uopOut.valid));
        while (stall) begin
            if (n == WAIT_LIMIT) begin
                reportProblem("stall never fell after the branch flush");
            end else begin
                tick();
                n++;
                assert (!uopOut.valid)
                    else reportMismatch("uopOut.valid", 64'd0, 64'(uopOut.valid));
            end
        end
        repeat (2) begin
            tick();
            assert (!uopOut.valid)
                else reportMismatch("uopOut.valid", 64'd0, 64'(uopOut.valid));
        end
        // Fill of a flushed miss still completes
        while (bursts.size() > 0) begin
            b = bursts.pop_front();
            if (!b.write) begin
                assert (b.base == flushLine)
                    else reportMismatch("memAddr", 64'(flushLine), 64'(b.base));
            end
        end
    endtask

    task automatic idleCycles(int count);
        uopIn = '0;
        repeat (count) begin
            tick();
            assert (!uopOut.valid)
                else reportMismatch("uopOut.valid", 64'd0, 64'(uopOut.valid));
        end
    endtask

    task automatic runStimulus(int fd);
        string cmd;
        string outcome;
        string rest;
        logic [31:0] addr;
        int sqN;
        int exc;
        int count;
        int code;
        logic done;
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else if (cmd == "//") begin
                code = $fgets(rest, fd);
            end else if (cmd == "uop") begin
                code = $fscanf(fd, "%h %d %d %s", addr, sqN, exc, outcome);
                if (code != 4) begin
                    reportProblem("malformed uop line in the stimulus file");
                end else begin
                    driveUop(addr, sqN, exc, outcome);
                end
            end else if (cmd == "branch") begin
                code = $fscanf(fd, "%d", sqN);
                if (code != 1) begin
                    reportProblem("malformed branch line in the stimulus file");
                end else begin
                    driveBranch(sqN);
                end
            end else if (cmd == "idle") begin
                code = $fscanf(fd, "%d", count);
                if (code != 1) begin
                    reportProblem("malformed idle line in the stimulus file");
                end else begin
                    idleCycles(count);
                end
            end else begin
                reportProblem($sformatf("unknown stimulus command %s", cmd));
            end
        end
    endtask

    initial begin
        int fd;
        uopIn = '0;
        branch = '0;
        rst = 1'b1;
        flushLine = '0;
        repeat (4) begin
            tick();
            checkQuiet();
        end
        rst = 1'b0;
        tick();
        checkQuiet();
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            reportProblem("could not open the stimulus file dv/cacheStimulus.txt");
        end else begin
            runStimulus(fd);
            $fclose(fd);
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* dv/cacheStimulus.txt */
// uop <addr hex> <sqN> <exception 0/1> <hit | miss | flush | writeback base hex>
// branch <sqN> flushes younger micro-ops, idle <cycles> sends nothing
idle 2
// Cold misses fill all four entries
uop 00001004 1 0 miss
uop 00001008 2 0 hit
uop 00002044 3 0 miss
uop 00003088 4 0 miss
uop 000040cc 5 0 miss
// Touch every resident line
uop 00001000 6 0 hit
uop 00002040 7 0 hit
uop 000030bc 8 0 hit
uop 000040c4 9 0 hit
// Exception goes around the lookup
uop 0000f000 10 1 hit
// Sweep clears all used bits and stops on the line at 000040c0
uop 00005100 11 0 000040c0
// Evicted line misses again, line 00001000 is next unused
uop 000040c0 12 0 00001000
uop 00005110 13 0 hit
// Older hit passes, younger hit is flushed
uop 00002048 14 0 hit
uop 0000308c 15 0 flush
branch 14
// sqN 1 is younger than 62 after wraparound
uop 000040c8 1 0 flush
branch 62
// Flush arrives while the miss waits for its fill
uop 00006180 20 0 flush
idle 30
branch 19
uop 00006184 21 0 hit
uop 00003080 22 0 000040c0
uop 00007000 23 1 hit
uop 0000204c 24 0 hit
uop 00003090 25 0 hit
idle 4

/* vlog.f */
source/cachePkg.sv
source/uopIngress.sv
source/cacheController.sv
source/memController.sv
source/cacheSubsystem.sv
dv/cacheSubsystemTb.sv

/* Makefile */
SIM      := verilator
TOP      := cacheSubsystemTb
FILELIST := vlog.f
OBJDIR   := obj_dir
FLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJDIR) --top-module $(TOP)

SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
EXE      := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(EXE)
	./$(EXE)

clean:
	rm -rf $(OBJDIR)
